// ==== include/mips_fetch_defines.svh ====
`ifndef MIPS_FETCH_DEFINES_SVH
`define MIPS_FETCH_DEFINES_SVH

// reset vector of the boot ROM in kseg1
`define MIPS_BOOT_VECTOR 32'hBFC00000

// requests instruction memory can hold at once
`define FETCH_CREDITS 4

// return address register for jal and the al branches
`define LINK_REG 5'd31

`endif

// ==== design/mips_fetch_pkg.sv ====
package mips_fetch_pkg;

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        op_special = 6'b000000,
        op_regimm  = 6'b000001,
        op_j       = 6'b000010,
        op_jal     = 6'b000011,
        op_beq     = 6'b000100,
        op_bne     = 6'b000101,
        op_blez    = 6'b000110,
        op_bgtz    = 6'b000111
    } opcode_e;

    // special function field, instr[5:0]
    typedef enum logic [5:0] {
        fn_jr   = 6'b001000,
        fn_jalr = 6'b001001
    } funct_e;

    typedef enum logic [1:0] {
        kind_none,
        kind_jump_abs,   // j, jal
        kind_jump_reg,   // jr, jalr
        kind_branch_rel  // conditional branches
    } branch_kind_e;

    // instruction at the current pc with its register operands
    typedef struct packed {
        logic [31:0] word;
        logic [31:0] rs_data;
        logic [31:0] rt_data;
    } instr_in_t;

    typedef struct packed {
        logic         taken;
        branch_kind_e kind;
        logic         link;
        logic [4:0]   link_rd;
        logic [31:0]  rs_target;
        logic [25:0]  imm26;
        logic [15:0]  offset16;
    } branch_res_t;

    // return address write to the register file
    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
    } link_wr_t;

endpackage

// ==== design/branch_resolve.sv ====
`timescale 1ns/1ns
`include "mips_fetch_defines.svh"

module branch_resolve (
    input  mips_fetch_pkg::instr_in_t   instr,
    output mips_fetch_pkg::branch_res_t res
);
    import mips_fetch_pkg::*;

    opcode_e     opcode;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  sa;
    logic [5:0]  funct;
    logic        rt_zero;
    logic        sa_zero;

    // condition flags on the signed operands
    logic        rs_eq_rt;
    logic        rs_gtz;
    logic        rs_eqz;
    logic        rs_ltz;

    assign opcode  = opcode_e'(instr.word[31:26]);
    assign rt      = instr.word[20:16];
    assign rd      = instr.word[15:11];
    assign sa      = instr.word[10:6];
    assign funct   = instr.word[5:0];
    assign rt_zero = (rt == 5'd0);
    assign sa_zero = (sa == 5'd0);

    assign rs_eq_rt = (instr.rs_data == instr.rt_data);
    assign rs_gtz   = ($signed(instr.rs_data) > 32'sd0);
    assign rs_eqz   = (instr.rs_data == 32'd0);
    assign rs_ltz   = instr.rs_data[31];

    always_comb begin
        res.taken     = 1'b0;
        res.kind      = kind_none;
        res.link      = 1'b0;
        res.link_rd   = `LINK_REG;
        res.rs_target = instr.rs_data;
        res.imm26     = instr.word[25:0];
        res.offset16  = instr.word[15:0];

        case (opcode)
            op_j: begin
                res.kind  = kind_jump_abs;
                res.taken = 1'b1;
            end
            op_jal: begin
                res.kind  = kind_jump_abs;
                res.taken = 1'b1;
                res.link  = 1'b1;
            end
            op_special: begin
                if (rt_zero && sa_zero) begin
                    if (funct == fn_jr) begin
                        res.kind  = kind_jump_reg;
                        res.taken = 1'b1;
                    end else if (funct == fn_jalr) begin
                        res.kind    = kind_jump_reg;
                        res.taken   = 1'b1;
                        res.link    = 1'b1;
                        res.link_rd = rd;   // jalr links to rd
                    end
                end
            end
            op_beq: begin
                res.kind  = kind_branch_rel;
                res.taken = rs_eq_rt;
            end
            op_bne: begin
                res.kind  = kind_branch_rel;
                res.taken = !rs_eq_rt;
            end
            op_blez: begin
                if (rt_zero) begin
                    res.kind  = kind_branch_rel;
                    res.taken = rs_eqz || rs_ltz;
                end
            end
            op_bgtz: begin
                if (rt_zero) begin
                    res.kind  = kind_branch_rel;
                    res.taken = rs_gtz;
                end
            end
            op_regimm: begin
                // rt: bltz 00000, bgez 00001, bltzal 10000, bgezal 10001
                if (rt[3:1] == 3'b000) begin
                    res.kind  = kind_branch_rel;
                    res.taken = rt[0] ? !rs_ltz : rs_ltz;
                    res.link  = rt[4];
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== design/mips_cpu_pc.sv ====
`timescale 1ns/1ns
`include "mips_fetch_defines.svh"

module mips_cpu_pc (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        instr_valid,
    input  logic                        credit_ok,
    input  mips_fetch_pkg::branch_res_t res,
    output logic [31:0]                 pc,
    output logic                        fetch_valid,
    output logic [31:0]                 fetch_addr,
    output logic                        link_valid,
    output mips_fetch_pkg::link_wr_t    link
);
    import mips_fetch_pkg::*;

    logic        step;
    logic        delay_q;     // current pc is a delay slot
    logic [31:0] target_q;
    logic [31:0] pc_plus4;
    logic [31:0] target_abs;
    logic [31:0] target_rel;
    logic [31:0] target_sel;
    logic [31:0] next_pc;
    logic        branch_now;

    assign step     = instr_valid && credit_ok;
    assign pc_plus4 = pc + 32'd4;

    assign target_abs = {pc_plus4[31:28], res.imm26, 2'b00};   // region of delay slot
    assign target_rel = pc_plus4 + {{14{res.offset16[15]}}, res.offset16, 2'b00};

    always_comb begin
        case (res.kind)
            kind_jump_abs:   target_sel = target_abs;
            kind_jump_reg:   target_sel = res.rs_target;
            kind_branch_rel: target_sel = target_rel;
            default:         target_sel = pc_plus4;
        endcase
    end

    // the delay slot itself is never resolved as a branch
    assign branch_now = res.taken && !delay_q;

    assign next_pc     = delay_q ? target_q : pc_plus4;
    assign fetch_valid = step;
    assign fetch_addr  = next_pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc         <= `MIPS_BOOT_VECTOR;
            delay_q    <= 1'b0;
            link_valid <= 1'b0;
        end else begin
            link_valid <= step && branch_now && res.link;
            if (step) begin
                pc      <= next_pc;
                delay_q <= branch_now;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step && branch_now) begin
            target_q <= target_sel;
        end
        if (step && branch_now && res.link) begin
            link.rd   <= res.link_rd;
            link.data <= pc + 32'd8;   // return past the delay slot
        end
    end

endmodule

// ==== design/fetch_credit_ctr.sv ====
`timescale 1ns/1ns
`include "mips_fetch_defines.svh"

module fetch_credit_ctr (
    input  logic clk,
    input  logic rst_n,
    input  logic fetch_valid,
    input  logic credit_return,
    output logic credit_ok
);
    localparam int CNT_W = $clog2(`FETCH_CREDITS + 1);
    localparam logic [CNT_W-1:0] MAX_CREDITS = CNT_W'(`FETCH_CREDITS);

    logic [CNT_W-1:0] count;

    assign credit_ok = (count != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= MAX_CREDITS;
        end else begin
            case ({fetch_valid, credit_return})
                2'b10: count <= count - 1'b1;
                2'b01: begin
                    if (count != MAX_CREDITS) begin   // ignore stray returns
                        count <= count + 1'b1;
                    end
                end
                default: ;   // both or neither, net zero
            endcase
        end
    end

endmodule

// ==== design/mips_fetch_top.sv ====
`timescale 1ns/1ns

module mips_fetch_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_valid,
    input  mips_fetch_pkg::instr_in_t instr,
    input  logic                      credit_return,
    output logic [31:0]               pc,
    output logic                      fetch_valid,
    output logic [31:0]               fetch_addr,
    output logic                      link_valid,
    output mips_fetch_pkg::link_wr_t  link
);
    import mips_fetch_pkg::*;

    branch_res_t res;
    logic        credit_ok;

    branch_resolve u_resolve (
        .instr (instr),
        .res   (res)
    );

    mips_cpu_pc u_pc (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .credit_ok   (credit_ok),
        .res         (res),
        .pc          (pc),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .link_valid  (link_valid),
        .link        (link)
    );

    fetch_credit_ctr u_credit (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_valid   (fetch_valid),   // one credit per request
        .credit_return (credit_return),
        .credit_ok     (credit_ok)
    );

endmodule

// ==== testbench/mips_fetch_asserts.sv ====
`timescale 1ns/1ns
`include "mips_fetch_defines.svh"

module mips_fetch_asserts (
    input logic        clk,
    input logic        rst_n,
    input logic        fetch_valid,
    input logic [3:0]  count,
    input logic [31:0] pc,
    input logic        link_valid
);

    a_no_req_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(fetch_valid && count == 4'd0))
        else $error("fetch request issued with no credit left");

    a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
        count <= `FETCH_CREDITS)
        else $error("credit count above its maximum");

    a_pc_aligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

    a_link_rst: assert property (@(posedge clk) !rst_n |-> !link_valid)
        else $error("link_valid high during reset");

endmodule

bind fetch_credit_ctr mips_fetch_asserts credit_chk (
    .clk(clk), .rst_n(rst_n), .fetch_valid(fetch_valid), .count(4'(count)),
    .pc(32'd0), .link_valid(1'b0)
);

bind mips_cpu_pc mips_fetch_asserts pc_chk (
    .clk(clk), .rst_n(rst_n), .fetch_valid(1'b0), .count(4'd1),
    .pc(pc), .link_valid(link_valid)
);

// ==== testbench/mips_fetch_tb.sv ====
`timescale 1ns/1ns
`include "mips_fetch_defines.svh"

module mips_fetch_tb;
    import mips_fetch_pkg::*;

    localparam int N_ENTRIES = 50;
    localparam int MAX_CYCLES = 20 * N_ENTRIES;
    localparam logic [31:0] END_PC = `MIPS_BOOT_VECTOR + 32'd4 * (N_ENTRIES - 1);

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    instr_in_t   instr;
    logic        credit_return;
    logic [31:0] pc;
    logic        fetch_valid;
    logic [31:0] fetch_addr;
    logic        link_valid;
    link_wr_t    link;

    logic [31:0] tbl_word [N_ENTRIES];
    logic [31:0] tbl_rs   [N_ENTRIES];
    logic [31:0] tbl_rt   [N_ENTRIES];
    logic [31:0] tbl_next [N_ENTRIES];

    // reference model state
    logic [31:0] m_pc;
    logic        m_delay;
    logic [31:0] m_target;
    logic        m_link_pend;
    logic [4:0]  m_link_rd;
    logic [31:0] m_link_data;
    int          tb_credits;
    int          link_count;
    int          errors;
    int          cycles;
    int          seed;
    int          due_q[$];   // cycle at which each credit comes back

    mips_fetch_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .credit_return (credit_return),
        .pc            (pc),
        .fetch_valid   (fetch_valid),
        .fetch_addr    (fetch_addr),
        .link_valid    (link_valid),
        .link          (link)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: program did not reach its end within %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic set_entry(input int k, input logic [31:0] word, input logic [31:0] rs,
                             input logic [31:0] rt, input int nk);
        tbl_word[k] = word;
        tbl_rs[k]   = rs;
        tbl_rt[k]   = rt;
        tbl_next[k] = `MIPS_BOOT_VECTOR + 32'd4 * nk;
    endtask

    // expected outcome of the instruction at m_pc, from the ISA rules
    task automatic model_step(input logic [31:0] word, input logic [31:0] rs,
                              input logic [31:0] rt, output logic [31:0] next);
        logic        taken;
        logic        lnk;
        logic [4:0]  rd;
        logic [31:0] tgt;
        logic [31:0] seq;
        logic [31:0] off;
        taken = 1'b0;
        lnk   = 1'b0;
        rd    = 5'd31;
        seq   = m_pc + 32'd4;
        off   = {{14{word[15]}}, word[15:0], 2'b00};
        tgt   = seq + off;
        case (word[31:26])
            6'd2, 6'd3: begin
                taken = 1'b1;
                lnk   = (word[31:26] == 6'd3);
                tgt   = {seq[31:28], word[25:0], 2'b00};
            end
            6'd0: begin
                if (word[20:16] == 5'd0 && word[10:6] == 5'd0 &&
                    (word[5:0] == 6'd8 || word[5:0] == 6'd9)) begin
                    taken = 1'b1;
                    lnk   = (word[5:0] == 6'd9);
                    rd    = word[15:11];
                    tgt   = rs;
                end
            end
            6'd4: taken = (rs == rt);
            6'd5: taken = (rs != rt);
            6'd6: taken = ($signed(rs) <= 0);
            6'd7: taken = ($signed(rs) > 0);
            6'd1: begin
                if (word[20:16] == 5'd0 || word[20:16] == 5'd16) taken = ($signed(rs) < 0);
                if (word[20:16] == 5'd1 || word[20:16] == 5'd17) taken = ($signed(rs) >= 0);
                lnk = word[20];
            end
            default: ;
        endcase
        m_link_pend = 1'b0;
        if (m_delay) begin
            next    = m_target;
            m_delay = 1'b0;
        end else begin
            next = seq;
            if (taken) begin
                m_delay  = 1'b1;
                m_target = tgt;
                if (lnk) begin
                    m_link_pend = 1'b1;
                    m_link_rd   = rd;
                    m_link_data = m_pc + 32'd8;
                end
            end
        end
    endtask

    initial begin
        int          idx;
        logic        exp_step;
        logic [31:0] next;
        seed = 85475;
        errors = 0;
        cycles = 0;
        link_count = 0;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        credit_return = 1'b0;
        for (int k = 0; k < N_ENTRIES; k++) set_entry(k, 32'h0, 32'h0, 32'h0, k + 1);
        set_entry(1,  32'h0BF00004, 32'h0, 32'h0, 2);            // j
        set_entry(2,  32'h0, 32'h0, 32'h0, 4);
        set_entry(4,  32'h0FF00007, 32'h0, 32'h0, 5);            // jal
        set_entry(5,  32'h0, 32'h0, 32'h0, 7);
        set_entry(7,  32'h00200008, 32'hBFC00030, 32'h0, 8);     // jr
        set_entry(8,  32'h0, 32'h0, 32'h0, 12);
        set_entry(12, 32'h00202809, 32'hBFC00040, 32'h0, 13);    // jalr to r5
        set_entry(13, 32'h0, 32'h0, 32'h0, 16);
        set_entry(16, 32'h10220003, 32'd5, 32'd5, 17);           // beq taken
        set_entry(17, 32'h0, 32'h0, 32'h0, 20);
        set_entry(20, 32'h10220003, 32'd5, 32'd6, 21);
        set_entry(21, 32'h14220002, 32'd1, 32'd2, 22);           // bne taken
        set_entry(22, 32'h0, 32'h0, 32'h0, 24);
        set_entry(24, 32'h14220002, 32'd7, 32'd7, 25);
        set_entry(25, 32'h1C200002, 32'd3, 32'h0, 26);           // bgtz taken
        set_entry(26, 32'h0, 32'h0, 32'h0, 28);
        set_entry(28, 32'h1C200002, 32'd0, 32'h0, 29);
        set_entry(29, 32'h18200002, 32'd0, 32'h0, 30);           // blez taken
        set_entry(30, 32'h0, 32'h0, 32'h0, 32);
        set_entry(32, 32'h18200002, 32'd9, 32'h0, 33);
        set_entry(33, 32'h04200002, 32'hFFFFFFF0, 32'h0, 34);    // bltz taken
        set_entry(34, 32'h0, 32'h0, 32'h0, 36);
        set_entry(36, 32'h04210002, 32'h80000000, 32'h0, 37);    // bgez not taken
        set_entry(37, 32'h04310002, 32'd0, 32'h0, 38);           // bgezal taken
        set_entry(38, 32'h0, 32'h0, 32'h0, 40);
        set_entry(40, 32'h04300002, 32'd5, 32'h0, 41);           // bltzal not taken
        set_entry(41, 32'h04210002, 32'd0, 32'h0, 42);
        set_entry(42, 32'h0, 32'h0, 32'h0, 44);
        set_entry(44, 32'h04300002, 32'hFFFFFFFF, 32'h0, 45);    // bltzal taken
        set_entry(45, 32'h0, 32'h0, 32'h0, 47);
        set_entry(47, 32'h04200002, 32'd1, 32'h0, 48);           // bltz not taken
        set_entry(48, 32'h04310002, 32'hFFFFFFF8, 32'h0, 49);    // bgezal not taken
        m_pc = `MIPS_BOOT_VECTOR;
        m_delay = 1'b0;
        m_link_pend = 1'b0;
        tb_credits = `FETCH_CREDITS;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        while (m_pc != END_PC) begin
            @(posedge clk);
            idx = (m_pc - `MIPS_BOOT_VECTOR) >> 2;
            if (idx >= N_ENTRIES) begin
                errors++;
                $display("pc model left the program table at %h", m_pc);
                idx = 0;
            end
            instr_valid   <= ($random(seed) & 3) != 0;   // about one gap in four
            instr         <= '{word: tbl_word[idx], rs_data: tbl_rs[idx], rt_data: tbl_rt[idx]};
            credit_return <= 1'b0;
            if (due_q.size() > 0 && due_q[0] <= cycles) begin
                credit_return <= 1'b1;
                void'(due_q.pop_front());
            end
            @(negedge clk);
            exp_step = instr_valid && (tb_credits > 0);
            check_val("pc", pc, m_pc);
            check_val("fetch_valid", fetch_valid, exp_step);
            check_val("link_valid", link_valid, m_link_pend);
            if (m_link_pend) begin
                check_val("link.rd", link.rd, m_link_rd);
                check_val("link.data", link.data, m_link_data);
                link_count++;
            end
            m_link_pend = 1'b0;
            if (exp_step) begin
                model_step(instr.word, instr.rs_data, instr.rt_data, next);
                check_val("fetch_addr", fetch_addr, next);
                check_val("table_next", tbl_next[idx], next);
                m_pc = next;
                due_q.push_back(cycles + 1 + ($unsigned($random(seed)) % 4));
            end
            tb_credits = tb_credits - exp_step + credit_return;
        end
        @(negedge clk);
        check_val("pc", pc, m_pc);   // last step lands on the end address
        check_val("link_count", link_count, 4);
        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== mips_fetch_top.f ====
+incdir+include
design/mips_fetch_pkg.sv
design/branch_resolve.sv
design/mips_cpu_pc.sv
design/fetch_credit_ctr.sv
design/mips_fetch_top.sv
testbench/mips_fetch_asserts.sv
testbench/mips_fetch_tb.sv

// ==== Bender.yml ====
package:
  name: mips_fetch

sources:
  - include_dirs:
      - include
    files:
      - design/mips_fetch_pkg.sv
      - design/branch_resolve.sv
      - design/mips_cpu_pc.sv
      - design/fetch_credit_ctr.sv
      - design/mips_fetch_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/mips_fetch_asserts.sv
      - testbench/mips_fetch_tb.sv
